// File: logic/arb_pkg.sv
// Sizes, vector typedefs and the request bundle struct of the weighted arbiter
package arb_pkg;

  // ---------------------------------------------------------------------
  // Sizes
  // ---------------------------------------------------------------------

  localparam int num_requesters = 4;
  // Zero is not a legal weight
  localparam int max_weight = 7;
  // Saturation level of every accumulated weight
  localparam int max_acc_weight = 14;

  // Derived widths
  localparam int weight_width = $clog2(max_weight + 1);
  localparam int acc_weight_width = $clog2(max_acc_weight + 1);
  localparam int req_idx_width = $clog2(num_requesters);

  // Holds max_acc_weight + max_weight, plus a sign bit for the floor at zero
  localparam int acc_calc_width = $clog2(max_acc_weight + max_weight + 1) + 1;

  // ---------------------------------------------------------------------
  // Types
  // ---------------------------------------------------------------------

  // One bit per requester, for request, grant and priority class
  typedef logic [num_requesters-1:0] req_vec_t;

  typedef logic [weight_width-1:0] weight_t;

  typedef logic [acc_weight_width-1:0] acc_weight_t;

  // Round-robin pointer
  typedef logic [req_idx_width-1:0] req_idx_t;

  // Request bundle into the top level
  typedef struct packed {
    req_vec_t                         request;
    weight_t [num_requesters-1:0]     weights;
  } arb_req_t;

endpackage

// File: logic/arb_weight_counter.sv
// Saturating accumulated-weight counter with weighted increment and unit decrement
`timescale 1ns/1ps

module arb_weight_counter (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enable,
  input  logic                 replenish,
  input  arb_pkg::weight_t     weight,
  input  logic                 spend,
  output arb_pkg::acc_weight_t acc_weight
);

  import arb_pkg::*;

  // Signed working width so both limits apply to the full result
  logic signed [acc_calc_width-1:0] acc_ext;
  logic signed [acc_calc_width-1:0] incr_ext;
  logic signed [acc_calc_width-1:0] decr_ext;
  logic signed [acc_calc_width-1:0] sum;
  acc_weight_t                      acc_next;

  // Zero-extended operands
  assign acc_ext  = {{(acc_calc_width - acc_weight_width){1'b0}}, acc_weight};
  assign incr_ext = replenish ? {{(acc_calc_width - weight_width){1'b0}}, weight} : '0;
  assign decr_ext = {{(acc_calc_width - 1){1'b0}}, spend};

  // Add and subtract in one step, then clamp once
  assign sum = acc_ext + incr_ext - decr_ext;

  always_comb begin
    if (sum < 0) begin
      acc_next = '0;
    end else if (sum > max_acc_weight) begin
      acc_next = acc_weight_t'(max_acc_weight);
    end else begin
      acc_next = acc_weight_t'(sum);
    end
  end

  // ---------------------------------------------------------------------
  // Accumulated weight register
  // ---------------------------------------------------------------------

  // Holds its value while enable is low
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_weight <= '0;
    end else if (enable) begin
      acc_weight <= acc_next;
    end
  end

endmodule

// File: logic/arb_pri_rr.sv
// Two-class round-robin arbiter with a registered pointer and combinational grant
`timescale 1ns/1ps

module arb_pri_rr (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable_priority_update,
  input  arb_pkg::req_vec_t request,
  input  arb_pkg::req_vec_t high_priority,
  output arb_pkg::req_vec_t grant
);

  import arb_pkg::*;

  // Requests that fall in the high-priority class
  req_vec_t high_requests;
  logic     any_high_request;

  // Set the scan runs over
  req_vec_t candidates;

  // Round-robin state
  req_idx_t ptr;
  req_idx_t ptr_next;
  req_idx_t winner_idx;

  // ---------------------------------------------------------------------
  // Class selection
  // ---------------------------------------------------------------------

  assign high_requests    = request & high_priority;
  assign any_high_request = |high_requests;

  // Low-priority requests only compete when no high-priority one exists
  assign candidates = any_high_request ? high_requests : request;

  // ---------------------------------------------------------------------
  // Cyclic scan from the pointer
  // ---------------------------------------------------------------------

  // First candidate at or after ptr wins, wrapping past the top index
  always_comb begin
    logic     found;
    req_idx_t scan_idx;

    found      = 1'b0;
    scan_idx   = ptr;
    grant      = '0;
    winner_idx = ptr;
    for (int i = 0; i < num_requesters; i++) begin
      scan_idx = req_idx_t'(ptr + req_idx_t'(i));
      if (!found && candidates[scan_idx]) begin
        found           = 1'b1;
        grant[scan_idx] = 1'b1;
        winner_idx      = scan_idx;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Pointer update
  // ---------------------------------------------------------------------

  // Next search starts just past the winner
  always_comb begin
    if (winner_idx == req_idx_t'(num_requesters - 1)) begin
      ptr_next = '0;
    end else begin
      ptr_next = winner_idx + 1'b1;
    end
  end

  // Moves only on enabled cycles that produced a grant
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (enable_priority_update && (|grant)) begin
      ptr <= ptr_next;
    end
  end

endmodule

// File: logic/arb_wrr.sv
// Weighted round-robin arbiter top with replenish and spend control
`timescale 1ns/1ps

module arb_wrr (
  input  logic              clk,
  input  logic              reset,
  input  logic              enable_priority_update,
  input  arb_pkg::arb_req_t req,
  output arb_pkg::req_vec_t grant
);

  import arb_pkg::*;

  // Unpacked request bundle
  req_vec_t                     request;
  weight_t [num_requesters-1:0] weights;

  // Per-client accumulated weights and the class mask built from them
  acc_weight_t [num_requesters-1:0] acc_weight;
  req_vec_t                         high_priority;

  // Counter control
  logic     any_high_priority_request;
  logic     replenish;
  req_vec_t spend;

  assign request = req.request;
  assign weights = req.weights;

  // ---------------------------------------------------------------------
  // Priority arbitration
  // ---------------------------------------------------------------------

  // Grant is combinational from request and the registered state
  arb_pri_rr pri_rr0 (
    .clk                    (clk),
    .reset                  (reset),
    .enable_priority_update (enable_priority_update),
    .request                (request),
    .high_priority          (high_priority),
    .grant                  (grant)
  );

  // ---------------------------------------------------------------------
  // Replenish and spend
  // ---------------------------------------------------------------------

  assign any_high_priority_request = |(request & high_priority);

  // Refill every counter once no requester has credit left
  assign replenish = enable_priority_update && (|request) && !any_high_priority_request;

  // The winner pays one unit
  assign spend = enable_priority_update ? grant : '0;

  // ---------------------------------------------------------------------
  // Accumulated weights
  // ---------------------------------------------------------------------

  for (genvar i = 0; i < num_requesters; i++) begin : gen_counter
    arb_weight_counter counter0 (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable_priority_update),
      .replenish  (replenish),
      .weight     (weights[i]),
      .spend      (spend[i]),
      .acc_weight (acc_weight[i])
    );

    // Any credit left puts the client in the high class
    assign high_priority[i] = |acc_weight[i];
  end

endmodule

// File: tb/arb_wrr_checker.sv
// Reference model of the weighted arbiter, concurrent assertions on its grant, and the bind
`timescale 1ns/1ps

module arb_wrr_checker (
  input logic              clk,
  input logic              reset,
  input logic              enable_priority_update,
  input arb_pkg::arb_req_t req,
  input arb_pkg::req_vec_t grant
);

  import arb_pkg::*;

  // Read by the testbench when the run ends
  int unsigned fail_count = 0;

  // Model state
  req_idx_t    model_ptr;
  acc_weight_t model_acc [num_requesters];

  req_vec_t model_high;
  req_vec_t model_grant;
  req_idx_t model_ptr_next;
  logic     model_replenish;

  // All-request, unit-weight rotation that starts at reset
  logic     rotation_active;
  logic     rotation_inputs;
  req_idx_t rotation_idx;

  // ---------------------------------------------------------------------
  // Rules
  // ---------------------------------------------------------------------

  // High-priority requests first, then first in cyclic order from start
  function automatic req_vec_t expected_grant(input req_vec_t request, input req_vec_t high,
                                              input req_idx_t start);
    req_vec_t pool;
    int       idx;
    pool = ((request & high) != '0) ? (request & high) : request;
    for (int step = 0; step < num_requesters; step++) begin
      idx = (int'(start) + step) % num_requesters;
      if (pool[idx]) begin
        return req_vec_t'(1) << idx;
      end
    end
    return '0;
  endfunction

  function automatic req_idx_t index_after(input req_vec_t one_hot);
    int idx;
    idx = 0;
    for (int i = 0; i < num_requesters; i++) begin
      if (one_hot[i]) begin
        idx = i;
      end
    end
    return req_idx_t'((idx + 1) % num_requesters);
  endfunction

  // Add, subtract, then clamp to 0..max_acc_weight
  function automatic acc_weight_t next_acc(input acc_weight_t acc, input weight_t weight,
                                           input logic add, input logic take);
    int value;
    value = int'(acc);
    if (add) begin
      value += int'(weight);
    end
    if (take) begin
      value -= 1;
    end
    if (value < 0) begin
      value = 0;
    end else if (value > max_acc_weight) begin
      value = max_acc_weight;
    end
    return acc_weight_t'(value);
  endfunction

  function automatic logic weights_all(input arb_req_t bundle, input weight_t value);
    logic match;
    match = 1'b1;
    for (int i = 0; i < num_requesters; i++) begin
      match &= (bundle.weights[i] == value);
    end
    return match;
  endfunction

  function automatic logic weights_nonzero(input arb_req_t bundle);
    logic legal;
    legal = 1'b1;
    for (int i = 0; i < num_requesters; i++) begin
      legal &= (bundle.weights[i] != '0);
    end
    return legal;
  endfunction

  // ---------------------------------------------------------------------
  // Model
  // ---------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < num_requesters; i++) begin
      model_high[i] = (model_acc[i] != '0);
    end
  end

  assign model_grant     = expected_grant(req.request, model_high, model_ptr);
  assign model_ptr_next  = index_after(model_grant);
  assign model_replenish = enable_priority_update && (req.request != '0) &&
                           ((req.request & model_high) == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      model_ptr <= '0;
      for (int i = 0; i < num_requesters; i++) begin
        model_acc[i] <= '0;
      end
    end else if (enable_priority_update) begin
      for (int i = 0; i < num_requesters; i++) begin
        model_acc[i] <= next_acc(model_acc[i], req.weights[i], model_replenish, model_grant[i]);
      end
      if (model_grant != '0) begin
        model_ptr <= model_ptr_next;
      end
    end
  end

  assign rotation_inputs = enable_priority_update && (req.request == '1) &&
                           weights_all(req, weight_t'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      rotation_active <= 1'b1;
      rotation_idx    <= '0;
    end else if (rotation_active && rotation_inputs) begin
      rotation_idx <= rotation_idx + 1'b1;
    end else begin
      rotation_active <= 1'b0;
    end
  end

  // ---------------------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------------------

  // Holds in reset too
  grant_legal: assert property (@(posedge clk)
      $onehot0(grant) && ((grant & ~req.request) == '0))
    else begin
      $error("CHECK FAILED grant=%h request=%h", $sampled(grant), $sampled(req.request));
      fail_count++;
    end

  grant_present: assert property (@(posedge clk)
      (req.request != '0) |-> (grant != '0))
    else begin
      $error("CHECK FAILED grant=%h request=%h", $sampled(grant), $sampled(req.request));
      fail_count++;
    end

  frozen_state: assert property (@(posedge clk) disable iff (reset)
      (!$past(enable_priority_update) && !$past(reset) && (req.request == $past(req.request)))
      |-> (grant == $past(grant)))
    else begin
      $error("CHECK FAILED grant=%h expected=%h", $sampled(grant), $past(grant));
      fail_count++;
    end

  rotation: assert property (@(posedge clk) disable iff (reset)
      (rotation_active && rotation_inputs) |-> (grant == (req_vec_t'(1) << rotation_idx)))
    else begin
      $error("CHECK FAILED grant=%h expected=%h", $sampled(grant),
             req_vec_t'(1) << $sampled(rotation_idx));
      fail_count++;
    end

  model_agreement: assert property (@(posedge clk) disable iff (reset)
      grant == model_grant)
    else begin
      $error("CHECK FAILED grant=%h expected=%h", $sampled(grant), $sampled(model_grant));
      fail_count++;
    end

  weight_legal: assert property (@(posedge clk) disable iff (reset)
      weights_nonzero(req))
    else begin
      $error("A zero weight was presented on req, weights=%h", $sampled(req.weights));
      fail_count++;
    end

endmodule

bind arb_wrr arb_wrr_checker checker0 (
  .clk                    (clk),
  .reset                  (reset),
  .enable_priority_update (enable_priority_update),
  .req                    (req),
  .grant                  (grant)
);

// File: tb/arb_wrr_tb.sv
// Testbench for the weighted round-robin arbiter with LFSR stimulus phases and final report
`timescale 1ns/1ps

module arb_wrr_tb;

  import arb_pkg::*;

  logic     clk;
  logic     reset;
  logic     enable_priority_update;
  arb_req_t req;
  req_vec_t grant;

  // Random stimulus source
  logic [31:0] lfsr_state;
  int unsigned timeout_count;

  arb_wrr dut0 (
    .clk                    (clk),
    .reset                  (reset),
    .enable_priority_update (enable_priority_update),
    .req                    (req),
    .grant                  (grant)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ---------------------------------------------------------------------
  // Stimulus helpers
  // ---------------------------------------------------------------------

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  function logic [31:0] draw_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Zero is not a legal weight
  function weight_t draw_weight();
    weight_t value;
    value = weight_t'(draw_bits(weight_width));
    if (value == '0) begin
      value = weight_t'(1);
    end
    return value;
  endfunction

  function arb_req_t random_req(input req_vec_t request);
    arb_req_t bundle;
    bundle.request = request;
    for (int i = 0; i < num_requesters; i++) begin
      bundle.weights[i] = draw_weight();
    end
    return bundle;
  endfunction

  function automatic arb_req_t uniform_req(input req_vec_t request, input weight_t weight);
    arb_req_t bundle;
    bundle.request = request;
    for (int i = 0; i < num_requesters; i++) begin
      bundle.weights[i] = weight;
    end
    return bundle;
  endfunction

  task automatic drive(input logic enable, input arb_req_t value);
    @(posedge clk);
    enable_priority_update <= enable;
    req                    <= value;
  endtask

  // Grant sampled at the falling edge, away from input changes
  task automatic wait_for_grant(input req_vec_t expected, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (grant !== expected && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (grant !== expected) begin
      $display("Timed out after %0d cycles waiting for grant %h", limit, expected);
      timeout_count++;
    end
  endtask

  // ---------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------

  initial begin
    arb_req_t current;
    logic     enable;

    lfsr_state             = 32'hf9e3;
    timeout_count          = 0;
    reset                  = 1'b1;
    enable_priority_update = 1'b0;
    req                    = uniform_req('0, weight_t'(1));

    // Fifth edge releases reset together with the first rotation inputs
    repeat (4) @(posedge clk);
    drive(1'b1, uniform_req('1, weight_t'(1)));
    reset <= 1'b0;
    repeat (15) drive(1'b1, uniform_req('1, weight_t'(1)));

    // Fixed random weights, everyone requesting
    current = random_req('1);
    repeat (60) drive(1'b1, current);

    // Random requests and weights, enable toggling
    current = random_req(req_vec_t'(draw_bits(num_requesters)));
    for (int cycle = 0; cycle < 300; cycle++) begin
      if (draw_bits(2) == 0) begin
        current.request = req_vec_t'(draw_bits(num_requesters));
      end
      if (draw_bits(3) == 0) begin
        current = random_req(current.request);
      end
      enable = (draw_bits(1) != 0);
      drive(enable, current);
    end

    // Long single-client runs let idle counters saturate
    for (int i = 0; i < num_requesters; i++) begin
      current = random_req(req_vec_t'(1) << i);
      drive(1'b1, current);
      wait_for_grant(req_vec_t'(1) << i, 8);
      repeat (40) drive(1'b1, current);
    end

    // Idle
    drive(1'b1, uniform_req('0, weight_t'(1)));
    wait_for_grant('0, 8);
    repeat (10) drive(1'b1, uniform_req('0, weight_t'(1)));
    repeat (10) drive(1'b0, uniform_req('0, weight_t'(1)));

    @(negedge clk);
    $display("Assertion failures: %0d, timeouts: %0d",
             dut0.checker0.fail_count, timeout_count);
    if (dut0.checker0.fail_count == 0 && timeout_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: arb_wrr.f
logic/arb_pkg.sv
logic/arb_weight_counter.sv
logic/arb_pri_rr.sv
logic/arb_wrr.sv
tb/arb_wrr_checker.sv
tb/arb_wrr_tb.sv

// File: Makefile
# Verilator simulation of the weighted round-robin arbiter

SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP       = arb_wrr_tb
FILELIST  = arb_wrr.f
BUILD_DIR = obj_dir
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log
PASS_MSG  = test passed

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
